// File: run.sh
#!/bin/sh
# build and run the store unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module storeUnitTb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/VstoreUnitTb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "=== PASS ==="; then
    exit 0
fi
exit 1

// File: source/coreTypesPkg.sv
`default_nettype none

package coreTypesPkg;

    localparam int SqNWidth = 7;
    localparam int TagWidth = 7;

    typedef logic [SqNWidth-1:0] SqN;
    typedef logic [TagWidth-1:0] Tag;

    typedef enum logic [1:0] {
        FlagNone,
        FlagExcept,
        FlagOrdering
    } Flags;

    typedef struct packed {
        logic taken;
        SqN   sqN;
    } BranchProv;

    typedef struct packed {
        logic        valid;
        SqN          sqN;
        Tag          tagDst;
        logic [31:0] pc;
        Flags        flags;
    } ResUop;

    // a is younger than b in wrapping sqN order
    function automatic logic isYounger(SqN a, SqN b);
        SqN diff;
        diff = a - b;
        return $signed(diff) > 0;
    endfunction

endpackage

`default_nettype wire

// File: source/lsuTypesPkg.sv
`default_nettype none

package lsuTypesPkg;

    localparam int QueueDepth = 8;
    localparam int QueuePtrWidth = $clog2(QueueDepth);

    typedef logic [QueuePtrWidth-1:0] QueueIdx;
    typedef logic [QueuePtrWidth:0] QueuePtr; // extra wrap bit

    typedef enum logic [2:0] {
        OpSb,
        OpSh,
        OpSw,
        OpFsw,
        OpCboClean,
        OpCboInval,
        OpCboFlush
    } StoreOp;

    typedef enum logic [1:0] {
        CboNone,
        CboClean,
        CboInval,
        CboFlush
    } CboCode;

    typedef struct packed {
        StoreOp           opcode;
        logic [31:0]      srcA; // base
        logic [31:0]      srcB; // store data
        logic [11:0]      imm;
        coreTypesPkg::SqN sqN;
        coreTypesPkg::Tag tagDst;
        logic [31:0]      pc;
    } ExUop;

    typedef struct packed {
        logic [31:0]      addr;
        logic [31:0]      data;
        logic [3:0]       wmask;
        CboCode           cbo;
        coreTypesPkg::SqN sqN;
        logic             exception;
    } AguOp;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  wmask;
        CboCode      cbo;
    } MemWrite;

endpackage

`default_nettype wire

// File: source/storeAgu.sv
`timescale 1ns/1ps
`default_nettype none

module storeAgu (
    input  logic               clk,
    input  lsuTypesPkg::ExUop  inUop,
    input  logic               accept,
    output lsuTypesPkg::AguOp  stage,
    output coreTypesPkg::ResUop resUop
);

    logic [31:0]         addr;
    logic                misaligned;
    logic                except;
    logic [3:0]          wmask;
    logic [31:0]         data;
    lsuTypesPkg::CboCode cbo;
    coreTypesPkg::Flags  flags;

    assign addr = inUop.srcA + {{20{inUop.imm[11]}}, inUop.imm};

    // --------------------
    // exception check
    always_comb begin
        case (inUop.opcode)
            lsuTypesPkg::OpSh: misaligned = addr[0];
            lsuTypesPkg::OpSw,
            lsuTypesPkg::OpFsw: misaligned = |addr[1:0];
            default: misaligned = 1'b0;
        endcase
    end

    assign except = (addr == 32'b0) || misaligned; // null pointer too

    always_comb begin
        if (except) begin
            flags = coreTypesPkg::FlagExcept;
        end else if (inUop.opcode == lsuTypesPkg::OpCboInval
                || inUop.opcode == lsuTypesPkg::OpCboFlush) begin
            flags = coreTypesPkg::FlagOrdering;
        end else begin
            flags = coreTypesPkg::FlagNone;
        end
    end

    // --------------------
    // byte lanes
    always_comb begin
        wmask = 4'b0000;
        data = inUop.srcB;
        cbo = lsuTypesPkg::CboNone;
        case (inUop.opcode)
            lsuTypesPkg::OpSb: begin
                wmask = 4'b0001 << addr[1:0];
                data = inUop.srcB << {addr[1:0], 3'b000};
            end
            lsuTypesPkg::OpSh: begin
                wmask = addr[1] ? 4'b1100 : 4'b0011;
                data = addr[1] ? inUop.srcB << 16 : inUop.srcB;
            end
            lsuTypesPkg::OpSw,
            lsuTypesPkg::OpFsw: wmask = 4'b1111;
            lsuTypesPkg::OpCboClean: begin
                data = 32'b0;
                cbo = lsuTypesPkg::CboClean;
            end
            lsuTypesPkg::OpCboInval: begin
                data = 32'b0;
                cbo = lsuTypesPkg::CboInval;
            end
            lsuTypesPkg::OpCboFlush: begin
                data = 32'b0;
                cbo = lsuTypesPkg::CboFlush;
            end
            default: wmask = 4'b0000;
        endcase
    end

    // --------------------
    // stage register and writeback
    always_ff @(posedge clk) begin
        resUop.valid <= accept; // single-cycle pulse
        if (accept) begin
            stage.addr <= {addr[31:2], 2'b00};
            stage.data <= data;
            stage.wmask <= wmask;
            stage.cbo <= cbo;
            stage.sqN <= inUop.sqN;
            stage.exception <= except;

            resUop.sqN <= inUop.sqN;
            resUop.tagDst <= inUop.tagDst;
            resUop.pc <= inUop.pc;
            resUop.flags <= flags;
        end
    end

endmodule

`default_nettype wire

// File: source/storeCtrl.sv
`timescale 1ns/1ps
`default_nettype none

module storeCtrl (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    inValid,
    output logic                    inReady,
    input  coreTypesPkg::SqN        inSqN,
    input  coreTypesPkg::BranchProv branch,
    input  coreTypesPkg::SqN        stageSqN,
    input  logic                    stageExcept,
    input  logic                    enqReady,
    output logic                    accept,
    output logic                    stageValid,
    output logic                    enqValid
);

    typedef enum logic {
        CtrlRun,
        CtrlKilled
    } CtrlState;

    CtrlState state;
    logic     inKill;
    logic     stageKill;
    logic     stageLeaves;

    // --------------------
    // kill decisions
    assign inKill = branch.taken && coreTypesPkg::isYounger(inSqN, branch.sqN);
    assign stageKill = stageValid && branch.taken
        && coreTypesPkg::isYounger(stageSqN, branch.sqN);

    // --------------------
    // handshakes
    // stage frees up when empty, dropped for an exception, or moving on
    assign stageLeaves = !stageValid || stageExcept || enqReady;
    assign inReady = (state == CtrlRun) && stageLeaves;
    assign accept = inValid && inReady && !inKill;
    assign enqValid = stageValid && !stageExcept && !stageKill;

    // --------------------
    // stage occupancy and state
    always_ff @(posedge clk) begin
        if (rst) begin
            stageValid <= 1'b0;
            state <= CtrlKilled; // one idle cycle out of reset
        end else begin
            if (accept) begin
                stageValid <= 1'b1;
            end else if (stageLeaves || stageKill) begin
                stageValid <= 1'b0;
            end

            // bubble only when the kill left the stage empty
            if (stageKill && !accept) begin
                state <= CtrlKilled;
            end else begin
                state <= CtrlRun;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/storeQueue.sv
`timescale 1ns/1ps
`default_nettype none

module storeQueue (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    enqValid,
    output logic                    enqReady,
    input  lsuTypesPkg::AguOp       enqOp,
    input  coreTypesPkg::BranchProv branch,
    input  coreTypesPkg::SqN        commitSqN,
    output logic                    memValid,
    input  logic                    memReady,
    output lsuTypesPkg::MemWrite    memReq
);

    lsuTypesPkg::MemWrite entryReq [lsuTypesPkg::QueueDepth];
    coreTypesPkg::SqN     entrySqN [lsuTypesPkg::QueueDepth];

    lsuTypesPkg::QueuePtr head;
    lsuTypesPkg::QueuePtr tail;
    lsuTypesPkg::QueuePtr count;
    lsuTypesPkg::QueuePtr keepCnt;
    lsuTypesPkg::QueuePtr baseTail;
    lsuTypesPkg::MemWrite enqReq;
    logic                 full;
    logic                 empty;
    logic                 enq;
    logic                 pop;

    assign count = tail - head;
    assign empty = (head == tail);
    assign full = (head[lsuTypesPkg::QueuePtrWidth] != tail[lsuTypesPkg::QueuePtrWidth])
        && (head[lsuTypesPkg::QueuePtrWidth-1:0] == tail[lsuTypesPkg::QueuePtrWidth-1:0]);

    assign enqReady = !full;
    assign enq = enqValid && enqReady;
    assign enqReq = '{addr: enqOp.addr, data: enqOp.data, wmask: enqOp.wmask, cbo: enqOp.cbo};

    // --------------------
    // kill keeps the older entries counted from the head
    always_comb begin
        lsuTypesPkg::QueueIdx idx;
        keepCnt = '0;
        for (int i = 0; i < lsuTypesPkg::QueueDepth; i++) begin
            idx = head[lsuTypesPkg::QueuePtrWidth-1:0] + lsuTypesPkg::QueueIdx'(i);
            if (lsuTypesPkg::QueuePtr'(i) < count
                    && !coreTypesPkg::isYounger(entrySqN[idx], branch.sqN)) begin
                keepCnt = keepCnt + 1'b1;
            end
        end
    end

    assign baseTail = branch.taken ? head + keepCnt : tail; // tail pulled back on kill

    // --------------------
    // drain once the head is older than commitSqN
    assign memReq = entryReq[head[lsuTypesPkg::QueuePtrWidth-1:0]];
    assign memValid = !empty
        && coreTypesPkg::isYounger(commitSqN, entrySqN[head[lsuTypesPkg::QueuePtrWidth-1:0]]);
    assign pop = memValid && memReady;

    always_ff @(posedge clk) begin
        if (enq) begin
            entryReq[baseTail[lsuTypesPkg::QueuePtrWidth-1:0]] <= enqReq;
            entrySqN[baseTail[lsuTypesPkg::QueuePtrWidth-1:0]] <= enqOp.sqN;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head <= '0;
            tail <= '0;
        end else begin
            if (pop) begin
                head <= head + 1'b1;
            end
            tail <= baseTail + {{lsuTypesPkg::QueuePtrWidth{1'b0}}, enq};
        end
    end

endmodule

`default_nettype wire

// File: source/storeUnit.sv
`timescale 1ns/1ps
`default_nettype none

module storeUnit (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    inValid,
    output logic                    inReady,
    input  lsuTypesPkg::ExUop       inUop,
    input  coreTypesPkg::BranchProv branch,
    input  coreTypesPkg::SqN        commitSqN,
    output coreTypesPkg::ResUop     resUop,
    output logic                    memValid,
    input  logic                    memReady,
    output lsuTypesPkg::MemWrite    memReq
);

    logic              accept;
    logic              enqValid;
    logic              enqReady;
    lsuTypesPkg::AguOp stage;

    storeCtrl i_ctrl (
        .clk         (clk),
        .rst         (rst),
        .inValid     (inValid),
        .inReady     (inReady),
        .inSqN       (inUop.sqN),
        .branch      (branch),
        .stageSqN    (stage.sqN),
        .stageExcept (stage.exception),
        .enqReady    (enqReady),
        .accept      (accept),
        .stageValid  (),
        .enqValid    (enqValid)
    );

    storeAgu i_agu (
        .clk    (clk),
        .inUop  (inUop),
        .accept (accept),
        .stage  (stage),
        .resUop (resUop)
    );

    storeQueue i_queue (
        .clk       (clk),
        .rst       (rst),
        .enqValid  (enqValid),
        .enqReady  (enqReady),
        .enqOp     (stage),
        .branch    (branch),
        .commitSqN (commitSqN),
        .memValid  (memValid),
        .memReady  (memReady),
        .memReq    (memReq)
    );

endmodule

`default_nettype wire

// File: test/storeUnitTests.svh
`ifndef STORE_UNIT_TESTS_SVH
`define STORE_UNIT_TESTS_SVH

// --------------------
// lanes and alignment
task automatic testLanes();
    commitSqN = nextSqN; // hold everything in the queue
    for (int b = 0; b < 4; b++) begin
        issueStore(lsuTypesPkg::OpSb, 32'h1000_0100, $urandom, 12'(b));
    end
    issueStore(lsuTypesPkg::OpSh, 32'h1000_0200, $urandom, 12'd0);
    issueStore(lsuTypesPkg::OpSh, 32'h1000_0200, $urandom, 12'd2);
    issueStore(lsuTypesPkg::OpSw, 32'h1000_0308, $urandom, 12'hffc); // negative offset
    issueStore(lsuTypesPkg::OpFsw, 32'h1000_0400, $urandom, 12'd4);
    idle(2);
    assert (!memValid)
    else begin
        $display("FAIL %0t: uncommitted store presented to memory", $time);
        valueErrors++;
    end
    commitSqN = nextSqN;
    waitDrain();
endtask

task automatic testExceptions();
    commitSqN = nextSqN + coreTypesPkg::SqN'(8);
    issueStore(lsuTypesPkg::OpSb, 32'h0000_0010, $urandom, 12'hff0); // null
    issueStore(lsuTypesPkg::OpSh, 32'h2000_0000, $urandom, 12'd1);
    issueStore(lsuTypesPkg::OpSw, 32'h2000_0000, $urandom, 12'd2);
    issueStore(lsuTypesPkg::OpFsw, 32'h2000_0001, $urandom, 12'd0);
    issueStore(lsuTypesPkg::OpSh, 32'h2000_0000, $urandom, 12'd6);
    waitDrain();
endtask

task automatic testCbo();
    commitSqN = nextSqN + coreTypesPkg::SqN'(8);
    issueStore(lsuTypesPkg::OpCboClean, 32'h3000_0047, $urandom, 12'd0);
    issueStore(lsuTypesPkg::OpCboInval, 32'h3000_0080, $urandom, 12'd5);
    issueStore(lsuTypesPkg::OpCboFlush, 32'h3000_00c0, $urandom, 12'hffe);
    waitDrain();
endtask

// --------------------
// queue full and random drain
task automatic testBackpressure();
    commitSqN = nextSqN;
    for (int i = 0; i < 9; i++) begin
        issueStore(lsuTypesPkg::OpSw, 32'h4000_0000 + 32'(i * 4), $urandom, 12'd0);
    end
    idle(1);
    assert (!inReady && !memValid)
    else begin
        $display("FAIL %0t: inReady %b memValid %b with a full held queue", $time,
                 inReady, memValid);
        valueErrors++;
    end
    throttle = 1'b1;
    commitSqN = nextSqN + coreTypesPkg::SqN'(8);
    for (int i = 0; i < 6; i++) begin
        issueStore(lsuTypesPkg::OpSb, 32'h4000_1000, $urandom, 12'(i));
    end
    waitDrain();
    throttle = 1'b0;
endtask

// --------------------
// mispredict kill
task automatic testKill();
    coreTypesPkg::SqN brSqN;
    commitSqN = nextSqN;
    issueStore(lsuTypesPkg::OpSw, 32'h6000_0000, $urandom, 12'd0);
    issueStore(lsuTypesPkg::OpSh, 32'h6000_0010, $urandom, 12'd2);
    brSqN = nextSqN;
    nextSqN = nextSqN + coreTypesPkg::SqN'(1); // slot of the branch itself
    issueStore(lsuTypesPkg::OpSw, 32'h6000_0020, $urandom, 12'd0);
    issueStore(lsuTypesPkg::OpSb, 32'h6000_0030, $urandom, 12'd3);
    issueStore(lsuTypesPkg::OpSw, 32'h6000_0040, $urandom, 12'd0);
    killYounger(brSqN); // input, stage and two queue entries
    nextSqN = brSqN + coreTypesPkg::SqN'(1); // refetched path
    issueStore(lsuTypesPkg::OpSw, 32'h6000_0100, $urandom, 12'd0);
    issueStore(lsuTypesPkg::OpSb, 32'h6000_0104, $urandom, 12'd1);
    commitSqN = nextSqN;
    waitDrain();
endtask

`endif

// File: test/storeUnitTb.sv
`timescale 1ns/1ps
`default_nettype none

module storeUnitTb;

    logic                    clk;
    logic                    rst;
    logic                    inValid;
    logic                    inReady;
    lsuTypesPkg::ExUop       inUop;
    coreTypesPkg::BranchProv branch;
    coreTypesPkg::SqN        commitSqN;
    coreTypesPkg::ResUop     resUop;
    logic                    memValid;
    logic                    memReady;
    lsuTypesPkg::MemWrite    memReq;

    lsuTypesPkg::MemWrite expMem [$]; // expected writes in drain order
    coreTypesPkg::SqN     expSqN [$];
    coreTypesPkg::SqN     nextSqN;
    logic                 throttle;
    int                   valueErrors;
    int                   timeoutErrors;
    int                   acceptCount;
    int                   resCount;

    storeUnit i_dut (
        .clk       (clk),
        .rst       (rst),
        .inValid   (inValid),
        .inReady   (inReady),
        .inUop     (inUop),
        .branch    (branch),
        .commitSqN (commitSqN),
        .resUop    (resUop),
        .memValid  (memValid),
        .memReady  (memReady),
        .memReq    (memReq)
    );

    always #20 clk = ~clk;

    // --------------------
    // reference model
    function automatic logic younger(coreTypesPkg::SqN a, coreTypesPkg::SqN b);
        coreTypesPkg::SqN d;
        d = a - b;
        return d != '0 && !d[coreTypesPkg::SqNWidth-1]; // nonzero with the sign bit clear
    endfunction

    function automatic logic [31:0] effAddr(lsuTypesPkg::ExUop u);
        return u.srcA + 32'($signed(u.imm));
    endfunction

    function automatic logic faults(lsuTypesPkg::ExUop u);
        logic [31:0] a;
        a = effAddr(u);
        if (a == 32'd0)
            return 1'b1;
        if (u.opcode == lsuTypesPkg::OpSh)
            return a[0];
        if (u.opcode == lsuTypesPkg::OpSw || u.opcode == lsuTypesPkg::OpFsw)
            return a[1] | a[0];
        return 1'b0;
    endfunction

    function automatic coreTypesPkg::Flags expFlags(lsuTypesPkg::ExUop u);
        if (faults(u))
            return coreTypesPkg::FlagExcept;
        if (u.opcode == lsuTypesPkg::OpCboInval || u.opcode == lsuTypesPkg::OpCboFlush)
            return coreTypesPkg::FlagOrdering;
        return coreTypesPkg::FlagNone;
    endfunction

    function automatic lsuTypesPkg::MemWrite expWrite(lsuTypesPkg::ExUop u);
        lsuTypesPkg::MemWrite w;
        logic [31:0]          a;
        int                   lane;
        a = effAddr(u);
        lane = int'(a[1:0]);
        w.addr = a & ~32'd3;
        w.data = u.srcB;
        w.wmask = 4'b0000;
        w.cbo = lsuTypesPkg::CboNone;
        case (u.opcode)
            lsuTypesPkg::OpSb: begin
                w.wmask = 4'b0001 << lane;
                w.data = u.srcB << (8 * lane);
            end
            lsuTypesPkg::OpSh: begin
                w.wmask = (lane >= 2) ? 4'b1100 : 4'b0011;
                w.data = (lane >= 2) ? u.srcB << 16 : u.srcB;
            end
            lsuTypesPkg::OpCboClean: w.cbo = lsuTypesPkg::CboClean;
            lsuTypesPkg::OpCboInval: w.cbo = lsuTypesPkg::CboInval;
            lsuTypesPkg::OpCboFlush: w.cbo = lsuTypesPkg::CboFlush;
            default: w.wmask = 4'b1111; // sw, fsw
        endcase
        return w;
    endfunction

    // --------------------
    // drivers
    task automatic idle(input int cycles);
        repeat (cycles) @(negedge clk);
    endtask

    // runs from a falling edge to the falling edge after acceptance
    task automatic issueStore(input lsuTypesPkg::StoreOp op, input logic [31:0] base,
                              input logic [31:0] wdata, input logic [11:0] offset);
        lsuTypesPkg::ExUop u;
        int                waited;
        u.opcode = op;
        u.srcA = base;
        u.srcB = wdata;
        u.imm = offset;
        u.sqN = nextSqN;
        u.tagDst = coreTypesPkg::Tag'($urandom);
        u.pc = $urandom;
        inUop = u;
        inValid = 1'b1;
        waited = 0;
        while (!inReady && waited < 50) begin
            @(negedge clk);
            waited++;
        end
        if (!inReady) begin
            $display("timeout: store with sqN %0d was never accepted", u.sqN);
            timeoutErrors++;
            inValid = 1'b0;
        end else begin
            @(negedge clk);
            inValid = 1'b0;
            acceptCount++;
            assert (resUop.valid && resUop.sqN == u.sqN && resUop.tagDst == u.tagDst
                    && resUop.pc == u.pc && resUop.flags == expFlags(u))
            else begin
                $display("FAIL %0t: result for sqN %0d valid %b flags %0d, expected flags %0d",
                         $time, u.sqN, resUop.valid, resUop.flags, expFlags(u));
                valueErrors++;
            end
            if (!faults(u)) begin
                expMem.push_back(expWrite(u));
                expSqN.push_back(u.sqN);
            end
            nextSqN = nextSqN + coreTypesPkg::SqN'(1);
        end
    endtask

    // mispredict at brSqN while a younger uop waits at the input
    task automatic killYounger(input coreTypesPkg::SqN brSqN);
        inUop.sqN = nextSqN;
        inUop.opcode = lsuTypesPkg::OpSw;
        inUop.srcA = 32'h5000_0000;
        inValid = 1'b1;
        branch.taken = 1'b1;
        branch.sqN = brSqN;
        @(negedge clk);
        inValid = 1'b0;
        branch.taken = 1'b0;
        assert (!resUop.valid)
        else begin
            $display("FAIL %0t: killed uop produced a result", $time);
            valueErrors++;
        end
        for (int i = expSqN.size() - 1; i >= 0; i--) begin
            if (younger(expSqN[i], brSqN)) begin
                expSqN.delete(i);
                expMem.delete(i);
            end
        end
    endtask

    task automatic waitDrain();
        int waited;
        waited = 0;
        while (expMem.size() > 0 && waited < 300) begin
            @(negedge clk);
            waited++;
        end
        if (expMem.size() > 0) begin
            $display("timeout: %0d expected writes never reached memory", expMem.size());
            timeoutErrors++;
        end
        idle(4); // room for any stray write
    endtask

    // --------------------
    // monitors
    task automatic checkWrite(input lsuTypesPkg::MemWrite exp, input coreTypesPkg::SqN sqN);
        assert (memReq.addr == exp.addr && memReq.wmask == exp.wmask && memReq.cbo == exp.cbo
                && (exp.wmask == 4'b0000 || memReq.data == exp.data))
        else begin
            $display("FAIL %0t: write sqN %0d got %h %b %h %0d, expected %h %b %h %0d", $time,
                     sqN, memReq.addr, memReq.wmask, memReq.data, memReq.cbo,
                     exp.addr, exp.wmask, exp.data, exp.cbo);
            valueErrors++;
        end
    endtask

    always @(posedge clk) begin
        if (!rst && resUop.valid === 1'b1) begin
            resCount++;
        end
    end

    always @(posedge clk) begin
        if (!rst && memValid && memReady) begin
            assert (expMem.size() > 0)
            else begin
                $display("FAIL %0t: unexpected write to %h", $time, memReq.addr);
                valueErrors++;
            end
            if (expMem.size() > 0) begin
                checkWrite(expMem.pop_front(), expSqN.pop_front());
            end
        end
    end

    initial begin
        memReady = 1'b1;
        forever begin
            @(negedge clk);
            memReady = !throttle || ($urandom % 4 != 0); // random stalls when throttled
        end
    end

    `include "storeUnitTests.svh"

    initial begin
        void'($urandom(32'h7a8f));
        clk = 1'b0;
        rst = 1'b1;
        inValid = 1'b0;
        inUop = '0;
        branch = '0;
        commitSqN = '0;
        throttle = 1'b0;
        nextSqN = '0;
        valueErrors = 0;
        timeoutErrors = 0;
        acceptCount = 0;
        resCount = 0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        assert (!inReady && !memValid && !resUop.valid)
        else begin
            $display("FAIL %0t: outputs active during reset", $time);
            valueErrors++;
        end
        rst = 1'b0;
        idle(2);

        testLanes();
        testExceptions();
        testCbo();
        testBackpressure();
        testKill();

        assert (resCount == acceptCount)
        else begin
            $display("FAIL %0t: %0d results for %0d accepted uops", $time, resCount, acceptCount);
            valueErrors++;
        end
        $display("errors: %0d value, %0d timeout", valueErrors, timeoutErrors);
        if (valueErrors == 0 && timeoutErrors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+test
source/coreTypesPkg.sv
source/lsuTypesPkg.sv
source/storeCtrl.sv
source/storeAgu.sv
source/storeQueue.sv
source/storeUnit.sv
test/storeUnitTb.sv
